//--- include/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// RAM depth in 32-bit words
`define MEM_WORDS 1024

// start of RAM in the byte address space
`define RAM_BASE 32'h0000_0000

// machine timer block
// offset 0 mtime low, 4 mtime high, 8 mtimecmp low, 12 mtimecmp high
// offset 16 holds the low word of the cycle counter
`define TIMER_BASE 32'h1000_0000

// any write here ends the program
`define EXIT_ADDR 32'h1000_0020

// clock cycles per mtime tick
`define TIME_DIV 4

`endif

//--- src/mem_pkg.sv
package mem_pkg;

    // width of a data access
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    // instruction fetch port
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } ireq_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
    } iresp_t;

    // data port, byte addressed
    typedef struct packed {
        logic        valid;
        logic        wen;
        mem_size_e   size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dreq_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } dresp_t;

    // memory bus, addr is the byte address of a whole word
    typedef struct packed {
        logic        valid;
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
    } bus_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } bus_resp_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_IFETCH,
        ARB_DATA,
        ARB_EXITED
    } arb_state_e;

    typedef enum logic [1:0] {
        SPL_IDLE,
        SPL_FIRST,
        SPL_SECOND,
        SPL_DONE
    } split_state_e;

endpackage

//--- src/timer_counters.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module timer_counters (
    input  logic        clkConstrained,
    input  logic        arst_n,
    output logic [63:0] cycle,
    output logic [63:0] mtime
);

    localparam int unsigned DIV_W = ($clog2(`TIME_DIV) > 0) ? $clog2(`TIME_DIV) : 1;

    logic [DIV_W-1:0] prescale;

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            cycle    <= 64'h0;
            mtime    <= 64'h0;
            prescale <= '0;
        end else begin
            cycle <= cycle + 64'd1;
            // one time tick per TIME_DIV clocks
            if (prescale == DIV_W'(`TIME_DIV - 1)) begin
                prescale <= '0;
                mtime    <= mtime + 64'd1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

//--- src/memory_map.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module memory_map (
    input  logic               clkConstrained,
    input  logic               arst_n,
    input  mem_pkg::bus_req_t  bus_req,
    output logic               bus_ready,
    output mem_pkg::bus_resp_t bus_resp,
    input  logic [63:0]        mtime,
    input  logic [63:0]        cycle,
    output logic               timer_irq,
    output logic               exited
);

    localparam int unsigned IDX_W        = $clog2(`MEM_WORDS);
    localparam logic [31:0] RAM_BASE_A   = `RAM_BASE;
    localparam logic [31:0] RAM_BYTES    = `MEM_WORDS * 4;
    localparam logic [31:0] TIMER_BASE_A = `TIMER_BASE;
    localparam logic [31:0] EXIT_ADDR_A  = `EXIT_ADDR;

    logic [31:0]      ram [`MEM_WORDS];
    logic [31:0]      ram_off;
    logic [IDX_W-1:0] ram_idx;
    logic             hit_ram;
    logic             hit_timer;
    logic             hit_exit;
    logic             xfer;
    logic             resp_valid_q;
    logic [31:0]      rdata_q;
    logic [31:0]      mmio_rdata;
    logic [63:0]      mtimecmp;

    // one response in flight at a time
    assign bus_ready = !resp_valid_q;
    assign xfer      = bus_req.valid && bus_ready;

    assign ram_off   = bus_req.addr - RAM_BASE_A;
    assign ram_idx   = ram_off[IDX_W+1:2];
    assign hit_ram   = ram_off < RAM_BYTES;
    assign hit_timer = bus_req.addr[31:5] == TIMER_BASE_A[31:5];
    assign hit_exit  = bus_req.addr == EXIT_ADDR_A;

    always_comb begin
        mmio_rdata = 32'h0;
        if (hit_timer) begin
            case (bus_req.addr[4:2])
                3'd0:    mmio_rdata = mtime[31:0];
                3'd1:    mmio_rdata = mtime[63:32];
                3'd2:    mmio_rdata = mtimecmp[31:0];
                3'd3:    mmio_rdata = mtimecmp[63:32];
                3'd4:    mmio_rdata = cycle[31:0];
                default: mmio_rdata = 32'h0;
            endcase
        end
    end

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid_q <= 1'b0;
            mtimecmp     <= '1;
            exited       <= 1'b0;
        end else begin
            resp_valid_q <= xfer;
            if (xfer && bus_req.wen && hit_timer) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_req.wmask[b] && bus_req.addr[4:2] == 3'd2) begin
                        mtimecmp[b*8 +: 8] <= bus_req.wdata[b*8 +: 8];
                    end
                    if (bus_req.wmask[b] && bus_req.addr[4:2] == 3'd3) begin
                        mtimecmp[32 + b*8 +: 8] <= bus_req.wdata[b*8 +: 8];
                    end
                end
            end
            if (xfer && bus_req.wen && hit_exit) begin
                exited <= 1'b1;
            end
        end
    end

    // byte-masked RAM, read data registered for the response cycle
    always_ff @(posedge clkConstrained) begin
        if (xfer) begin
            if (hit_ram && bus_req.wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_req.wmask[b]) begin
                        ram[ram_idx][b*8 +: 8] <= bus_req.wdata[b*8 +: 8];
                    end
                end
            end
            rdata_q <= hit_ram ? ram[ram_idx] : mmio_rdata;
        end
    end

    always_comb begin
        bus_resp.valid = resp_valid_q;
        bus_resp.rdata = rdata_q;
    end

    assign timer_irq = mtime >= mtimecmp;

endmodule

//--- src/mem_cmd_arbiter.sv
`timescale 1ns/1ps

module mem_cmd_arbiter (
    input  logic               clkConstrained,
    input  logic               arst_n,
    input  logic               exited,
    input  mem_pkg::ireq_t     ireq,
    output mem_pkg::iresp_t    iresp,
    input  mem_pkg::dreq_t     dreq,
    output mem_pkg::dresp_t    dresp,
    output mem_pkg::bus_req_t  bus_req,
    input  logic               bus_ready,
    input  mem_pkg::bus_resp_t bus_resp
);

    mem_pkg::arb_state_e state;
    mem_pkg::arb_state_e state_nxt;
    logic                sent_q;
    logic                spill_q;
    logic [3:0]          size_mask;
    logic [7:0]          span;
    logic                busy;

    always_comb begin
        case (dreq.size)
            mem_pkg::SIZE_B: size_mask = 4'b0001;
            mem_pkg::SIZE_H: size_mask = 4'b0011;
            default:         size_mask = 4'b1111;
        endcase
    end

    // byte lanes over two words with the upper half in the next word
    assign span = {4'b0000, size_mask} << dreq.addr[1:0];
    assign busy = (state == mem_pkg::ARB_IFETCH) || (state == mem_pkg::ARB_DATA);

    always_comb begin
        state_nxt = state;
        case (state)
            mem_pkg::ARB_IDLE: begin
                // data side wins a tie
                if (exited) begin
                    state_nxt = mem_pkg::ARB_EXITED;
                end else if (dreq.valid) begin
                    state_nxt = mem_pkg::ARB_DATA;
                end else if (ireq.valid) begin
                    state_nxt = mem_pkg::ARB_IFETCH;
                end
            end
            mem_pkg::ARB_IFETCH, mem_pkg::ARB_DATA: begin
                if (bus_resp.valid) begin
                    state_nxt = exited ? mem_pkg::ARB_EXITED : mem_pkg::ARB_IDLE;
                end
            end
            default: state_nxt = state;
        endcase
    end

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            state   <= mem_pkg::ARB_IDLE;
            sent_q  <= 1'b0;
            spill_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (busy && bus_resp.valid) begin
                sent_q <= 1'b0;
            end else if (bus_req.valid && bus_ready) begin
                sent_q <= 1'b1;
            end
            // the splitter sends the second half of a spilling access right after the first
            if (state == mem_pkg::ARB_DATA && bus_resp.valid) begin
                spill_q <= spill_q ? 1'b0 : (span[7:4] != 4'b0000);
            end
        end
    end

    always_comb begin
        bus_req.valid = busy && !sent_q;
        bus_req.wen   = (state == mem_pkg::ARB_DATA) && dreq.wen;
        bus_req.addr  = (state == mem_pkg::ARB_DATA) ? {dreq.addr[31:2], 2'b00}
                                                     : {ireq.addr[31:2], 2'b00};
        bus_req.wdata = dreq.wdata;
        bus_req.wmask = spill_q ? span[7:4] : span[3:0];
    end

    // route the response to whichever side holds the grant
    always_comb begin
        iresp.valid = (state == mem_pkg::ARB_IFETCH) && bus_resp.valid;
        iresp.inst  = bus_resp.rdata;
        dresp.valid = (state == mem_pkg::ARB_DATA) && bus_resp.valid;
        dresp.rdata = bus_resp.rdata;
    end

    // nothing reaches the bus once the exit register has been written
    assert property (@(posedge clkConstrained) disable iff (!arst_n)
        exited |-> !bus_req.valid)
        else $error("arbiter issued a bus request after exit");

endmodule

//--- src/unaligned_access.sv
`timescale 1ns/1ps

module unaligned_access (
    input  logic            clkConstrained,
    input  logic            arst_n,
    input  mem_pkg::dreq_t  core_req,
    output mem_pkg::dresp_t core_resp,
    output mem_pkg::dreq_t  mem_req,
    input  mem_pkg::dresp_t mem_resp
);

    mem_pkg::split_state_e state;
    mem_pkg::split_state_e state_nxt;
    logic [1:0]            off;
    logic [2:0]            nbytes;
    logic                  crossing;
    logic [31:0]           lo_q;
    logic [31:0]           hi_q;
    logic [63:0]           merged;

    assign off = core_req.addr[1:0];

    always_comb begin
        case (core_req.size)
            mem_pkg::SIZE_B: nbytes = 3'd1;
            mem_pkg::SIZE_H: nbytes = 3'd2;
            default:         nbytes = 3'd4;
        endcase
    end

    // spills into the next word
    assign crossing = ({1'b0, off} + nbytes) > 3'd4;

    always_comb begin
        state_nxt = state;
        case (state)
            mem_pkg::SPL_IDLE: begin
                if (core_req.valid) begin
                    state_nxt = mem_pkg::SPL_FIRST;
                end
            end
            mem_pkg::SPL_FIRST: begin
                if (mem_resp.valid) begin
                    state_nxt = crossing ? mem_pkg::SPL_SECOND : mem_pkg::SPL_DONE;
                end
            end
            mem_pkg::SPL_SECOND: begin
                if (mem_resp.valid) begin
                    state_nxt = mem_pkg::SPL_DONE;
                end
            end
            default: state_nxt = mem_pkg::SPL_IDLE;
        endcase
    end

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            state <= mem_pkg::SPL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (mem_resp.valid && state == mem_pkg::SPL_FIRST) begin
            lo_q <= mem_resp.rdata;
        end
        if (mem_resp.valid && state == mem_pkg::SPL_SECOND) begin
            hi_q <= mem_resp.rdata;
        end
    end

    // second half goes to the next word with its write data moved down to lane 0
    always_comb begin
        mem_req.valid = (state == mem_pkg::SPL_FIRST) || (state == mem_pkg::SPL_SECOND);
        mem_req.wen   = core_req.wen;
        mem_req.size  = core_req.size;
        if (state == mem_pkg::SPL_SECOND) begin
            mem_req.addr  = core_req.addr + 32'd4;
            mem_req.wdata = core_req.wdata >> {3'd4 - {1'b0, off}, 3'b000};
        end else begin
            mem_req.addr  = core_req.addr;
            mem_req.wdata = core_req.wdata << {off, 3'b000};
        end
    end

    // little-endian merge and zero-extend
    assign merged = {hi_q, lo_q} >> {off, 3'b000};

    always_comb begin
        core_resp.valid = (state == mem_pkg::SPL_DONE);
        case (core_req.size)
            mem_pkg::SIZE_B: core_resp.rdata = {24'h0, merged[7:0]};
            mem_pkg::SIZE_H: core_resp.rdata = {16'h0, merged[15:0]};
            default:         core_resp.rdata = merged[31:0];
        endcase
    end

    // an access touches at most two neighbouring words
    assert property (@(posedge clkConstrained) disable iff (!arst_n)
        (state == mem_pkg::SPL_SECOND && $past(state) == mem_pkg::SPL_FIRST)
        |-> (mem_req.addr[31:2] == $past(mem_req.addr[31:2]) + 30'd1))
        else $error("second half does not target the following word");

endmodule

//--- src/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic            clkConstrained,
    input  logic            arst_n,
    input  mem_pkg::ireq_t  ireq,
    output mem_pkg::iresp_t iresp,
    input  mem_pkg::dreq_t  dreq,
    output mem_pkg::dresp_t dresp,
    output logic            timer_irq,
    output logic            exited
);

    logic [63:0]        cycle;
    logic [63:0]        mtime;
    mem_pkg::bus_req_t  bus_req;
    logic               bus_ready;
    mem_pkg::bus_resp_t bus_resp;
    // aligned pieces between splitter and arbiter
    mem_pkg::dreq_t     split_req;
    mem_pkg::dresp_t    split_resp;

    timer_counters counters_i (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .cycle          (cycle),
        .mtime          (mtime)
    );

    memory_map memmap_i (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .bus_req        (bus_req),
        .bus_ready      (bus_ready),
        .bus_resp       (bus_resp),
        .mtime          (mtime),
        .cycle          (cycle),
        .timer_irq      (timer_irq),
        .exited         (exited)
    );

    mem_cmd_arbiter arbiter_i (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .exited         (exited),
        .ireq           (ireq),
        .iresp          (iresp),
        .dreq           (split_req),
        .dresp          (split_resp),
        .bus_req        (bus_req),
        .bus_ready      (bus_ready),
        .bus_resp       (bus_resp)
    );

    unaligned_access splitter_i (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .core_req       (dreq),
        .core_resp      (dresp),
        .mem_req        (split_req),
        .mem_resp       (split_resp)
    );

endmodule

//--- bench/tb_checker.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_checker (
    input  logic            clkConstrained,
    input  logic            arst_n,
    input  mem_pkg::ireq_t  ireq,
    input  mem_pkg::iresp_t iresp,
    input  mem_pkg::dreq_t  dreq,
    input  mem_pkg::dresp_t dresp,
    input  logic            timer_irq,
    input  logic            exited,
    input  int              test_id,
    input  int              n_ireq,
    input  int              n_dreq,
    input  logic            finish_req,
    output int              errors
);

    localparam int          RAM_BYTES = `MEM_WORDS * 4;
    localparam logic [31:0] TIMER_A   = `TIMER_BASE;
    localparam logic [31:0] EXIT_A    = `EXIT_ADDR;

    // byte copy of the RAM and the compare register
    logic [7:0]  mem_model [RAM_BYTES];
    logic [63:0] cmp_model     = '1;
    logic [31:0] last_mtime    = 32'h0;
    int          fetch_resps   = 0;
    int          data_resps    = 0;
    int          irq_wait      = 0;
    int          err_count     = 0;
    logic        reset_checked = 1'b0;
    logic        reported      = 1'b0;

    assign errors = err_count;

    function automatic string test_label(input int id);
        case (id)
            0: return "ram_fill";
            1: return "word_rw";
            2: return "subword_rw";
            3: return "fetch_mix";
            4: return "timer_regs";
            5: return "timer_irq";
            default: return "exit";
        endcase
    endfunction

    function automatic int size_bytes(input mem_pkg::mem_size_e size);
        if (size == mem_pkg::SIZE_B) return 1;
        if (size == mem_pkg::SIZE_H) return 2;
        return 4;
    endfunction

    function automatic logic timer_hit(input logic [31:0] addr);
        return addr[31:5] == TIMER_A[31:5];
    endfunction

    // little-endian, zero-extended load from the model
    function automatic logic [31:0] expected_read(input logic [31:0] addr,
                                                  input mem_pkg::mem_size_e size);
        logic [31:0] val;
        logic [31:0] a;
        val = 32'h0;
        if (timer_hit(addr)) begin
            if (addr[4:2] == 3'd2) val = cmp_model[31:0];
            if (addr[4:2] == 3'd3) val = cmp_model[63:32];
        end else begin
            for (int i = 0; i < size_bytes(size); i++) begin
                a = addr + i;
                val[i*8 +: 8] = mem_model[a % RAM_BYTES];
            end
        end
        return val;
    endfunction

    task automatic report_mismatch(input logic [31:0] exp, input logic [31:0] act);
        $display("CHECK FAILED %s: expected %h, actual %h", test_label(test_id), exp, act);
        err_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR in %s: %s", test_label(test_id), msg);
        err_count++;
    endtask

    task automatic record_write();
        logic [31:0] a;
        if (timer_hit(dreq.addr)) begin
            if (dreq.addr[4:2] == 3'd2) cmp_model[31:0] = dreq.wdata;
            if (dreq.addr[4:2] == 3'd3) cmp_model[63:32] = dreq.wdata;
            // small compare value, irq has to follow soon
            if (cmp_model[63:8] == 56'h0) irq_wait = 50;
            if (cmp_model == '1 && timer_irq) report_mismatch(32'h0, 32'h1);
        end else if (dreq.addr == EXIT_A) begin
            if (!exited) report_mismatch(32'h1, 32'h0);
        end else begin
            for (int i = 0; i < size_bytes(dreq.size); i++) begin
                a = dreq.addr + i;
                mem_model[a % RAM_BYTES] = dreq.wdata[i*8 +: 8];
            end
        end
    endtask

    always @(negedge clkConstrained) begin
        if (arst_n) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (iresp.valid || dresp.valid || exited || timer_irq)
                    report_problem("outputs were not idle after reset");
            end
            if (iresp.valid) begin
                fetch_resps++;
                if (!ireq.valid) report_problem("fetch response with no fetch pending");
                else if (exited) report_problem("instruction fetch was answered after exit");
                else if (iresp.inst !== expected_read({ireq.addr[31:2], 2'b00}, mem_pkg::SIZE_W))
                    report_mismatch(expected_read({ireq.addr[31:2], 2'b00}, mem_pkg::SIZE_W),
                                    iresp.inst);
            end
            if (dresp.valid) begin
                data_resps++;
                if (!dreq.valid) begin
                    report_problem("data response with no request pending");
                end else if (dreq.wen) begin
                    record_write();
                end else if (timer_hit(dreq.addr) && dreq.addr[4:2] == 3'd0) begin
                    // mtime low must never go backwards
                    if (dresp.rdata < last_mtime) report_mismatch(last_mtime, dresp.rdata);
                    last_mtime = dresp.rdata;
                end else if (dresp.rdata !== expected_read(dreq.addr, dreq.size)) begin
                    report_mismatch(expected_read(dreq.addr, dreq.size), dresp.rdata);
                end
            end
            if (irq_wait > 0) begin
                if (timer_irq) begin
                    irq_wait = 0;
                end else begin
                    irq_wait--;
                    if (irq_wait == 0) report_problem("timer_irq did not rise within 50 cycles");
                end
            end
            if (finish_req && !reported) begin
                reported = 1'b1;
                if (fetch_resps != n_ireq) report_problem("fetch responses differ from fetches");
                if (data_resps != n_dreq) report_problem("data responses differ from requests");
                $display("summary: %0d fetch responses, %0d data responses, %0d errors",
                         fetch_resps, data_resps, err_count);
            end
        end
    end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_top;

    localparam int N_WORD      = 64;
    localparam int N_SUB       = 120;
    localparam int N_MIX       = 48;
    localparam int N_FETCH     = 48;
    // fill, word and sub-word pairs, mixed traffic, timer, exit and the last fetch
    localparam int N_REQ       = `MEM_WORDS + 2 * N_WORD + 2 * N_SUB + N_MIX + N_FETCH + 12;
    localparam int CYCLE_LIMIT = 40 * N_REQ + 200;
    localparam logic [31:0] TIMER_A = `TIMER_BASE;

    logic            clkConstrained;
    logic            arst_n;
    mem_pkg::ireq_t  ireq;
    mem_pkg::iresp_t iresp;
    mem_pkg::dreq_t  dreq;
    mem_pkg::dresp_t dresp;
    logic            timer_irq;
    logic            exited;
    logic            finish_req;
    int              test_id;
    int              n_ireq;
    int              n_dreq;
    int              errors;
    int              cycle_count = 0;
    logic [15:0]     lfsr_state  = 16'd6;
    logic [31:0]     fetch_addr [N_FETCH];
    logic [31:0]     word_addr [N_WORD];

    mem_subsystem_top dut_i (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .ireq           (ireq),
        .iresp          (iresp),
        .dreq           (dreq),
        .dresp          (dresp),
        .timer_irq      (timer_irq),
        .exited         (exited)
    );

    tb_checker checker_i (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .ireq           (ireq),
        .iresp          (iresp),
        .dreq           (dreq),
        .dresp          (dresp),
        .timer_irq      (timer_irq),
        .exited         (exited),
        .test_id        (test_id),
        .n_ireq         (n_ireq),
        .n_dreq         (n_dreq),
        .finish_req     (finish_req),
        .errors         (errors)
    );

    initial begin
        clkConstrained = 1'b0;
        forever #50 clkConstrained = ~clkConstrained;
    end

    always @(posedge clkConstrained) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic mem_pkg::mem_size_e rand_size();
        logic [1:0] b;
        b = 2'(take_bits(2));
        if (b == 2'd0) return mem_pkg::SIZE_B;
        if (b == 2'd1) return mem_pkg::SIZE_H;
        return mem_pkg::SIZE_W;
    endfunction

    // multiply spreads every address bit over the word
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr * 32'h9E37_79B1 + 32'h0F0F_1234;
    endfunction

    task automatic data_access(input logic wen, input mem_pkg::mem_size_e size,
                               input logic [31:0] addr, input logic [31:0] wdata);
        mem_pkg::dreq_t req;
        req.valid = 1'b1;
        req.wen   = wen;
        req.size  = size;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clkConstrained);
        dreq <= req;
        n_dreq++;
        @(negedge clkConstrained);
        while (!dresp.valid) @(negedge clkConstrained);
        @(posedge clkConstrained);
        dreq.valid <= 1'b0;
    endtask

    task automatic fetch(input logic [31:0] addr);
        @(posedge clkConstrained);
        ireq.addr  <= addr;
        ireq.valid <= 1'b1;
        n_ireq++;
        @(negedge clkConstrained);
        while (!iresp.valid) @(negedge clkConstrained);
        @(posedge clkConstrained);
        ireq.valid <= 1'b0;
    endtask

    initial begin
        logic [31:0]        addr;
        logic [31:0]        data;
        mem_pkg::mem_size_e size;
        arst_n     <= 1'b0;
        ireq       <= '0;
        dreq       <= '0;
        finish_req <= 1'b0;
        test_id = 0;
        n_ireq  = 0;
        n_dreq  = 0;
        repeat (16) @(posedge clkConstrained);
        arst_n <= 1'b1;

        for (int w = 0; w < `MEM_WORDS; w++) begin
            data_access(1'b1, mem_pkg::SIZE_W, w * 4, fill_word(w * 4));
        end

        test_id = 1;
        for (int i = 0; i < N_WORD; i++) begin
            word_addr[i] = take_bits(10) << 2;
            data = take_bits(32);
            data_access(1'b1, mem_pkg::SIZE_W, word_addr[i], data);
        end
        for (int i = 0; i < N_WORD; i++) begin
            data_access(1'b0, mem_pkg::SIZE_W, word_addr[i], 32'h0);
        end

        // sub-word and misaligned, kept clear of the last word of RAM
        test_id = 2;
        for (int i = 0; i < N_SUB; i++) begin
            size = rand_size();
            addr = take_bits(12) % 32'd4088;
            data = take_bits(32);
            data_access(1'b1, size, addr, data);
            size = rand_size();
            data_access(1'b0, size, addr, 32'h0);
        end

        // fetches use the lower half while data traffic stays in the upper half
        test_id = 3;
        for (int i = 0; i < N_FETCH; i++) begin
            fetch_addr[i] = take_bits(11);
        end
        fork
            begin
                logic                 wen;
                logic [31:0]          maddr;
                logic [31:0]          mdata;
                mem_pkg::mem_size_e   msize;
                for (int i = 0; i < N_MIX; i++) begin
                    wen   = take_bits(1) != 0;
                    msize = rand_size();
                    maddr = 32'd2048 + take_bits(11) % 32'd2040;
                    mdata = take_bits(32);
                    data_access(wen, msize, maddr, mdata);
                end
            end
            begin
                for (int i = 0; i < N_FETCH; i++) begin
                    fetch(fetch_addr[i]);
                end
            end
        join

        test_id = 4;
        data_access(1'b0, mem_pkg::SIZE_W, TIMER_A, 32'h0);
        data_access(1'b1, mem_pkg::SIZE_W, TIMER_A + 8, take_bits(32));
        data_access(1'b1, mem_pkg::SIZE_W, TIMER_A + 12, 32'h8000_0000 | take_bits(32));
        data_access(1'b0, mem_pkg::SIZE_W, TIMER_A + 8, 32'h0);
        data_access(1'b0, mem_pkg::SIZE_W, TIMER_A + 12, 32'h0);
        data_access(1'b0, mem_pkg::SIZE_W, TIMER_A, 32'h0);

        test_id = 5;
        data_access(1'b1, mem_pkg::SIZE_W, TIMER_A + 8, 32'd16);
        data_access(1'b1, mem_pkg::SIZE_W, TIMER_A + 12, 32'h0);
        for (int i = 0; i < 60 && !timer_irq; i++) @(negedge clkConstrained);
        data_access(1'b1, mem_pkg::SIZE_W, TIMER_A + 12, 32'hFFFF_FFFF);
        data_access(1'b1, mem_pkg::SIZE_W, TIMER_A + 8, 32'hFFFF_FFFF);

        // after exit a fetch must stay unanswered
        test_id = 6;
        data_access(1'b1, mem_pkg::SIZE_W, `EXIT_ADDR, 32'h1);
        @(posedge clkConstrained);
        ireq.addr  <= 32'h40;
        ireq.valid <= 1'b1;
        repeat (30) @(posedge clkConstrained);
        ireq.valid <= 1'b0;

        @(posedge clkConstrained);
        finish_req <= 1'b1;
        repeat (2) @(negedge clkConstrained);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
src/mem_pkg.sv
src/timer_counters.sv
src/memory_map.sv
src/mem_cmd_arbiter.sv
src/unaligned_access.sv
src/mem_subsystem_top.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message in the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f build.f -o tb_sim --Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && cat sim.log \
    && grep -q 'All tests passed!' sim.log \
    && echo "simulation passed" \
    || { cat build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
